/* logic/exec_pkg.sv */
package exec_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    // MIPS word and register number
    localparam int data_w     = 32;
    localparam int reg_addr_w = 5;

    typedef logic [data_w-1:0]     data_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    ////////////////////////////////////////////////////////////
    // Operation encodings
    ////////////////////////////////////////////////////////////

    // ALU operations, ADD and SUB are the trapping forms
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_addu = 4'd1,
        alu_sub  = 4'd2,
        alu_subu = 4'd3,
        alu_and  = 4'd4,
        alu_or   = 4'd5,
        alu_xor  = 4'd6,
        alu_nor  = 4'd7,
        alu_slt  = 4'd8,
        alu_sltu = 4'd9,
        alu_lui  = 4'd10
    } alu_op_e;

    typedef enum logic [1:0] {
        shift_sll = 2'd0,
        shift_srl = 2'd1,
        shift_sra = 2'd2
    } shift_op_e;

    // Source of the value written back
    typedef enum logic [1:0] {
        res_alu   = 2'd0,
        res_shift = 2'd1,
        res_move  = 2'd2
    } res_sel_e;

    ////////////////////////////////////////////////////////////
    // Stage payloads
    ////////////////////////////////////////////////////////////

    // Decoded instruction entering EX
    typedef struct packed {
        alu_op_e   alu_op;
        shift_op_e shift_op;
        logic [4:0] shamt;
        logic      shamt_sel;   // 1: amount from rs
        logic      b_sel;       // 1: immediate on B
        data_t     imm;
        res_sel_e  res_sel;
        logic      reg_w;
        logic      of_w_disen;  // drop write on overflow
        logic      movz;
        logic      movn;
        reg_addr_t rs_addr;
        reg_addr_t rt_addr;
        reg_addr_t rd_addr;
        data_t     rs_data;
        data_t     rt_data;
    } ex_op_t;

    // EX/MEM contents
    typedef struct packed {
        reg_addr_t rd_addr;
        logic      reg_w;
        data_t     data;
    } ex_res_t;

    // Operands after forwarding and selection
    typedef struct packed {
        data_t      a;
        data_t      b;
        data_t      rt_fwd;
        logic [4:0] shamt;
    } operands_t;

endpackage

/* logic/operand_forward.sv */
module operand_forward import exec_pkg::*; (
    input  ex_op_t    op,
    input  logic      res_valid,
    input  ex_res_t   res,
    output operands_t operands
);

    ////////////////////////////////////////////////////////////
    // EX/MEM forwarding
    ////////////////////////////////////////////////////////////

    // Previous result usable for this source register
    function automatic logic fwd_hit(
        input logic      valid,
        input ex_res_t   prev,
        input reg_addr_t src
    );
        // $0 is hardwired, never forward into it
        return valid && prev.reg_w && (prev.rd_addr == src) && (src != '0);
    endfunction

    logic  rs_hit;
    logic  rt_hit;
    data_t rs_fwd;
    data_t rt_fwd;

    assign rs_hit = fwd_hit(res_valid, res, op.rs_addr);
    assign rt_hit = fwd_hit(res_valid, res, op.rt_addr);

    // Forwarded register values
    assign rs_fwd = rs_hit ? res.data : op.rs_data;
    assign rt_fwd = rt_hit ? res.data : op.rt_data;

    ////////////////////////////////////////////////////////////
    // Operand selection
    ////////////////////////////////////////////////////////////

    always_comb begin
        operands.a      = rs_fwd;
        // Shifter input and MOVZ/MOVN test
        operands.rt_fwd = rt_fwd;
        // I-type ops take the extended immediate
        operands.b      = op.b_sel ? op.imm : rt_fwd;
        // SLLV/SRLV/SRAV use low bits of rs
        if (op.shamt_sel) begin
            operands.shamt = rs_fwd[4:0];
        end else begin
            operands.shamt = op.shamt;
        end
    end

endmodule

/* logic/alu.sv */
module alu import exec_pkg::*; (
    input  alu_op_e   alu_op,
    input  operands_t operands,
    output data_t     alu_res,
    output logic      overflow
);

    data_t a;
    data_t b;
    data_t sum;
    data_t diff;
    logic  add_of;
    logic  sub_of;
    logic  lt_signed;
    logic  lt_unsigned;

    assign a = operands.a;
    assign b = operands.b;

    ////////////////////////////////////////////////////////////
    // Adder and subtractor
    ////////////////////////////////////////////////////////////

    assign sum  = a + b;
    assign diff = a - b;

    // Same signs in, different sign out
    assign add_of = (a[data_w-1] == b[data_w-1]) && (sum[data_w-1] != a[data_w-1]);
    // Opposite signs in, result sign differs from A
    assign sub_of = (a[data_w-1] != b[data_w-1]) && (diff[data_w-1] != a[data_w-1]);

    // Set-on-less-than compares
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    ////////////////////////////////////////////////////////////
    // Operation select
    ////////////////////////////////////////////////////////////

    always_comb begin
        overflow = 1'b0;
        case (alu_op)
            alu_add: begin
                alu_res  = sum;
                overflow = add_of;
            end
            alu_addu: alu_res = sum;
            alu_sub: begin
                alu_res  = diff;
                overflow = sub_of;
            end
            alu_subu: alu_res = diff;
            alu_and:  alu_res = a & b;
            alu_or:   alu_res = a | b;
            alu_xor:  alu_res = a ^ b;
            alu_nor:  alu_res = ~(a | b);
            alu_slt:  alu_res = data_t'(lt_signed);
            alu_sltu: alu_res = data_t'(lt_unsigned);
            // Upper half from the immediate
            alu_lui:  alu_res = {b[15:0], 16'h0000};
            default:  alu_res = sum;
        endcase
    end

endmodule

/* logic/barrel_shifter.sv */
module barrel_shifter import exec_pkg::*; (
    input  shift_op_e shift_op,
    input  operands_t operands,
    output data_t     shift_res
);

    logic  is_left;
    logic  fill;
    data_t shift_in;
    data_t stage [0:5];

    assign is_left = (shift_op == shift_sll);
    // Sign bits only for SRA
    assign fill    = (shift_op == shift_sra) && operands.rt_fwd[data_w-1];

    // Left shift done as a right shift on the mirrored word
    always_comb begin
        for (int i = 0; i < data_w; i++) begin
            shift_in[i] = is_left ? operands.rt_fwd[data_w-1-i] : operands.rt_fwd[i];
        end
    end

    assign stage[0] = shift_in;

    // Log stages by 1, 2, 4, 8, 16
    for (genvar s = 0; s < 5; s++) begin : g_stage
        assign stage[s+1] = operands.shamt[s]
                          ? {{(1 << s){fill}}, stage[s][data_w-1:(1 << s)]}
                          : stage[s];
    end

    // Undo the mirror for SLL
    always_comb begin
        for (int i = 0; i < data_w; i++) begin
            shift_res[i] = is_left ? stage[5][data_w-1-i] : stage[5][i];
        end
    end

endmodule

/* logic/result_select.sv */
module result_select import exec_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      op_valid,
    input  ex_op_t    op,
    input  operands_t operands,
    input  data_t     alu_res,
    input  data_t     shift_res,
    input  logic      overflow,
    output logic      res_valid,
    output ex_res_t   res
);

    data_t ex_data;
    logic  rt_zero;
    logic  reg_w_gated;

    ////////////////////////////////////////////////////////////
    // Result mux
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (op.res_sel)
            res_alu:   ex_data = alu_res;
            res_shift: ex_data = shift_res;
            // MOVZ/MOVN pass rs through
            res_move:  ex_data = operands.a;
            default:   ex_data = alu_res;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Write enable gating
    ////////////////////////////////////////////////////////////

    assign rt_zero = (operands.rt_fwd == '0);

    always_comb begin
        reg_w_gated = op.reg_w;
        // Trapping ADD/SUB must not write on overflow
        if (op.of_w_disen && overflow) begin
            reg_w_gated = 1'b0;
        end
        // Conditional moves
        if (op.movz && !rt_zero) begin
            reg_w_gated = 1'b0;
        end
        if (op.movn && rt_zero) begin
            reg_w_gated = 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // EX/MEM register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        res.rd_addr <= op.rd_addr;
        res.data    <= ex_data;
        if (rst) begin
            res_valid <= 1'b0;
            res.reg_w <= 1'b0;
        end else begin
            res_valid <= op_valid;
            // Bubble never writes
            res.reg_w <= op_valid && reg_w_gated;
        end
    end

endmodule

/* logic/exec_stage.sv */
module exec_stage import exec_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    op_valid,
    input  ex_op_t  op,
    output logic    res_valid,
    output ex_res_t res
);

    ////////////////////////////////////////////////////////////
    // Internal wires
    ////////////////////////////////////////////////////////////

    operands_t operands;
    data_t     alu_res;
    data_t     shift_res;
    logic      overflow;

    ////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////

    // Forward from EX/MEM back into this op
    operand_forward u_operand_forward (
        .op        ( op ),
        .res_valid ( res_valid ),
        .res       ( res ),
        .operands  ( operands )
    );

    alu u_alu (
        .alu_op   ( op.alu_op ),
        .operands ( operands ),
        .alu_res  ( alu_res ),
        .overflow ( overflow )
    );

    barrel_shifter u_barrel_shifter (
        .shift_op  ( op.shift_op ),
        .operands  ( operands ),
        .shift_res ( shift_res )
    );

    // Final mux, write gating and EX/MEM
    result_select u_result_select (
        .clk       ( clk ),
        .rst       ( rst ),
        .op_valid  ( op_valid ),
        .op        ( op ),
        .operands  ( operands ),
        .alu_res   ( alu_res ),
        .shift_res ( shift_res ),
        .overflow  ( overflow ),
        .res_valid ( res_valid ),
        .res       ( res )
    );

endmodule

/* dv/exec_stage_props.sv */
module exec_stage_props import exec_pkg::*; (
    input logic    clk,
    input logic    rst,
    input logic    op_valid,
    input logic    res_valid,
    input ex_res_t res
);

    timeunit 1ns;
    timeprecision 1ps;

    // Fixed one-cycle latency
    a_valid_latency: assert property (
        @(posedge clk) !rst |=> (res_valid == $past(op_valid))
    ) else $error("res_valid does not follow op_valid by one cycle");

    a_reset_clears: assert property (
        @(posedge clk) rst |=> !res_valid
    ) else $error("res_valid high in the cycle after reset");

    // A bubble never writes
    a_write_needs_valid: assert property (
        @(posedge clk) res.reg_w |-> res_valid
    ) else $error("res.reg_w high while res_valid is low");

endmodule

bind exec_stage exec_stage_props i_props (
    .clk       ( clk ),
    .rst       ( rst ),
    .op_valid  ( op_valid ),
    .res_valid ( res_valid ),
    .res       ( res )
);

/* dv/exec_stage_tb.sv */
module exec_stage_tb import exec_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_ops      = 3000;
    localparam int rst_cycles = 16;

    // Expected EX/MEM output for one cycle
    typedef struct packed {
        logic    valid;
        ex_res_t res;
    } expect_t;

    logic    clk;
    logic    rst;
    logic    op_valid;
    ex_op_t  op;
    logic    res_valid;
    ex_res_t res;

    integer  seed;
    int      n_errors;
    int      n_compares;
    expect_t exp_q [$];

    exec_stage i_dut (
        .clk       ( clk ),
        .rst       ( rst ),
        .op_valid  ( op_valid ),
        .op        ( op ),
        .res_valid ( res_valid ),
        .res       ( res )
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    // Corner values for overflow and the MOVZ/MOVN zero test
    function automatic data_t pick_data();
        logic [3:0] kind;
        kind = 4'($random(seed));
        case (kind)
            4'd0:    return '0;
            4'd1:    return 32'h7fff_ffff;
            4'd2:    return 32'h8000_0000;
            default: return data_t'($random(seed));
        endcase
    endfunction

    function automatic ex_op_t rand_op();
        ex_op_t      o;
        logic [1:0]  kind;
        logic [15:0] imm16;
        o     = '0;
        kind  = 2'($random(seed));
        imm16 = 16'($random(seed));
        o.alu_op    = alu_op_e'(4'($unsigned($random(seed)) % 11));
        o.shift_op  = shift_op_e'(2'($unsigned($random(seed)) % 3));
        o.shamt     = 5'($random(seed));
        o.shamt_sel = 1'($random(seed));
        o.b_sel     = 1'($random(seed));
        o.imm       = {{16{imm16[15]}}, imm16};
        o.reg_w     = (3'($random(seed)) != 3'd0);
        // Small register set so sources often hit the last rd
        o.rs_addr   = 5'($unsigned($random(seed)) % 4);
        o.rt_addr   = 5'($unsigned($random(seed)) % 4);
        o.rd_addr   = 5'($unsigned($random(seed)) % 4);
        o.rs_data   = pick_data();
        o.rt_data   = pick_data();
        case (kind)
            2'd2: o.res_sel = res_shift;
            2'd3: begin
                o.res_sel = res_move;
                o.b_sel   = 1'b0;
                o.movz    = 1'($random(seed));
                o.movn    = !o.movz;
            end
            default: begin
                o.res_sel    = res_alu;
                o.of_w_disen = 1'($random(seed));
            end
        endcase
        return o;
    endfunction

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic ex_res_t ref_result(input ex_op_t o, input logic prev_valid,
                                           input ex_res_t prev);
        data_t      a;
        data_t      rt;
        data_t      b;
        logic [4:0] sh;
        data_t      alu_val;
        data_t      shift_val;
        logic       ovf;
        longint     wide;
        ex_res_t    r;
        // Forward the last result except into $0
        a  = o.rs_data;
        rt = o.rt_data;
        if (prev_valid && prev.reg_w && prev.rd_addr == o.rs_addr && o.rs_addr != '0) begin
            a = prev.data;
        end
        if (prev_valid && prev.reg_w && prev.rd_addr == o.rt_addr && o.rt_addr != '0) begin
            rt = prev.data;
        end
        b   = o.b_sel ? o.imm : rt;
        sh  = o.shamt_sel ? a[4:0] : o.shamt;
        ovf = 1'b0;
        case (o.alu_op)
            alu_add: begin
                wide    = longint'($signed(a)) + longint'($signed(b));
                alu_val = wide[31:0];
                // Overflow when the true sum does not fit 32 signed bits
                ovf     = (wide != longint'($signed(alu_val)));
            end
            alu_sub: begin
                wide    = longint'($signed(a)) - longint'($signed(b));
                alu_val = wide[31:0];
                ovf     = (wide != longint'($signed(alu_val)));
            end
            alu_addu: alu_val = a + b;
            alu_subu: alu_val = a - b;
            alu_and:  alu_val = a & b;
            alu_or:   alu_val = a | b;
            alu_xor:  alu_val = a ^ b;
            alu_nor:  alu_val = ~(a | b);
            alu_slt:  alu_val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sltu: alu_val = (a < b) ? 32'd1 : 32'd0;
            alu_lui:  alu_val = b << 16;
            default:  alu_val = '0;
        endcase
        case (o.shift_op)
            shift_sll: shift_val = rt << sh;
            shift_srl: shift_val = rt >> sh;
            default:   shift_val = data_t'($signed(rt) >>> sh);
        endcase
        r.rd_addr = o.rd_addr;
        case (o.res_sel)
            res_shift: r.data = shift_val;
            res_move:  r.data = a;
            default:   r.data = alu_val;
        endcase
        r.reg_w = o.reg_w && !(o.of_w_disen && ovf) && !(o.movz && rt != '0)
                  && !(o.movn && rt == '0);
        return r;
    endfunction

    task automatic check_result(input expect_t e);
        n_compares++;
        assert (res_valid === e.valid) else begin
            $display("FAIL %0t: res_valid %b, expected %b", $time, res_valid, e.valid);
            n_errors++;
        end
        assert (res.reg_w === e.res.reg_w) else begin
            $display("FAIL %0t: reg_w %b, expected %b", $time, res.reg_w, e.res.reg_w);
            n_errors++;
        end
        // Address and data only mean something on a valid result
        if (e.valid) begin
            assert (res.rd_addr === e.res.rd_addr) else begin
                $display("FAIL %0t: rd_addr %0d, expected %0d", $time, res.rd_addr,
                         e.res.rd_addr);
                n_errors++;
            end
            assert (res.data === e.res.data) else begin
                $display("FAIL %0t: data %h, expected %h", $time, res.data, e.res.data);
                n_errors++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Drive, compare, watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        expect_t e;
        expect_t model;
        seed       = 1315;
        rst        = 1'b1;
        op_valid   = 1'b0;
        op         = '0;
        model      = '0;
        n_errors   = 0;
        n_compares = 0;
        // Ops offered during reset must be dropped
        repeat (rst_cycles - 1) begin
            @(negedge clk);
            op       = rand_op();
            op_valid = 1'($random(seed));
            e        = '0;
            exp_q.push_back(e);
        end
        for (int i = 0; i < n_ops; i++) begin
            @(negedge clk);
            rst      = 1'b0;
            op       = rand_op();
            op_valid = (4'($random(seed)) != 4'd0);
            e        = '0;
            if (op_valid) begin
                e.valid = 1'b1;
                e.res   = ref_result(op, model.valid, model.res);
            end
            // Idle cycle breaks the forwarding chain
            model = e;
            exp_q.push_back(e);
        end
        @(negedge clk);
        op_valid = 1'b0;
        e        = '0;
        exp_q.push_back(e);
        @(negedge clk);
        $display("Summary: %0d compares, %0d errors", n_compares, n_errors);
        if (n_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Outputs settle well before 1 ns past the edge
    initial begin
        expect_t e;
        forever begin
            @(posedge clk);
            #1;
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                check_result(e);
            end
        end
    end

    initial begin
        #((rst_cycles + n_ops + 10) * 10 + 1000);
        $display("Watchdog timeout: the stimulus did not finish in time");
        $display("Checks failed");
        $finish;
    end

endmodule

/* src.f */
logic/exec_pkg.sv
logic/operand_forward.sv
logic/alu.sv
logic/barrel_shifter.sv
logic/result_select.sv
logic/exec_stage.sv
dv/exec_stage_props.sv
dv/exec_stage_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module exec_stage_tb -Mdir obj_dir -f src.f

out=$(./obj_dir/Vexec_stage_tb)
echo "$out"
echo "$out" | grep -q "All checks passed"
